// File: build.f
hdl/apb_pkg.sv
hdl/ext_mem_pkg.sv
hdl/apb_mem_decode.sv
hdl/sram_port.sv
hdl/nand_port.sv
hdl/ext_mem_top.sv
verif/mem_models.sv
verif/ext_mem_tb.sv

// File: Makefile
SRCS := $(shell grep '\.sv$$' build.f)

obj_dir/Vext_mem_tb: build.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module ext_mem_tb

run: obj_dir/Vext_mem_tb
	./obj_dir/Vext_mem_tb | tee /dev/stderr | grep '>>> PASS' > /dev/null

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: verif/ext_mem_tb.sv
module ext_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import apb_pkg::*;
    import ext_mem_pkg::*;

    localparam int APB_TIMEOUT = 64;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    sram_pins_t  sram_pins;
    byte_t       sram_din;
    nand_pins_t  nand_pins;
    byte_t       nand_din;
    logic        nand_rb;
    logic [31:0] lcg_state      = 32'hc40c_e673;
    int          errors         = 0;
    int          tests_failed   = 0;
    int          strobe_cycles  = 0;
    int          overlap_cycles = 0;
    int          drive_faults   = 0;
    byte_t       shadow [0:32767];

    ext_mem_top i_ext_mem_top
    (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .sram_pins (sram_pins),
        .sram_din  (sram_din),
        .nand_pins (nand_pins),
        .nand_din  (nand_din),
        .nand_rb   (nand_rb)
    );

    sram_model i_sram_model (.clk(clk), .pins(sram_pins), .dout(sram_din));
    nand_model i_nand_model (.pins(nand_pins), .dout(nand_din));

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bus activity seen on the pins.
    always @(posedge clk)
    begin
        if (!sram_pins.ce_n || !nand_pins.nce)
            strobe_cycles <= strobe_cycles + 1;
        if (nand_pins.cle && nand_pins.ale)
            overlap_cycles <= overlap_cycles + 1;
        // data bus drives on a write strobe and floats on a read strobe.
        if ((!sram_pins.we_n && !sram_pins.oe) || (!sram_pins.oe_n && sram_pins.oe) ||
            (!nand_pins.nwe && !nand_pins.oe) || (!nand_pins.nre && nand_pins.oe))
            drive_faults <= drive_faults + 1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, output apb_data_t rdata,
                                output logic slverr);
        int waited;
        waited = 0;
        rdata  = '0;
        slverr = 1'b0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!apb_rsp.pready && (waited < APB_TIMEOUT));
        if (apb_rsp.pready)
        begin
            rdata  = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
        end
        else
        begin
            $display("APB transfer to 0x%h got no pready within %0d cycles", addr, APB_TIMEOUT);
            errors++;
        end
        apb_req <= '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic slverr);
        apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic slverr);
        apb_transfer(1'b0, addr, 8'h00, data, slverr);
    endtask

    task automatic report_result(input string name, input int err_before);
        if (errors == err_before)
            $display("%-18s ok", name);
        else
        begin
            $display("%-18s failed, %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    task automatic check_reset_state();
        int err_before;
        err_before = errors;
        @(posedge clk);
        if ({sram_pins.ce_n, sram_pins.we_n, sram_pins.oe_n, sram_pins.oe} != 4'b1110)
        begin
            $display("[ERROR] reset_state: sram ce_n/we_n/oe_n/oe expected 1110 actual %b",
                     {sram_pins.ce_n, sram_pins.we_n, sram_pins.oe_n, sram_pins.oe});
            errors++;
        end
        if ({nand_pins.nce, nand_pins.nwe, nand_pins.nre,
             nand_pins.cle, nand_pins.ale, nand_pins.oe} != 6'b111000)
        begin
            $display("[ERROR] reset_state: nce/nwe/nre/cle/ale/oe expected 111000 actual %b",
                     {nand_pins.nce, nand_pins.nwe, nand_pins.nre,
                      nand_pins.cle, nand_pins.ale, nand_pins.oe});
            errors++;
        end
        if ({apb_rsp.pready, apb_rsp.pslverr} != 2'b00)
        begin
            $display("[ERROR] reset_state: pready/pslverr expected 00 actual %b",
                     {apb_rsp.pready, apb_rsp.pslverr});
            errors++;
        end
        report_result("reset_state", err_before);
    endtask

    task automatic sram_write_read();
        apb_addr_t   addrs [16];
        logic [31:0] r;
        apb_data_t   rd;
        logic        err;
        logic        err_seen;
        int          faults_before;
        int          err_before;
        err_before    = errors;
        err_seen      = 1'b0;
        faults_before = drive_faults;
        for (int i = 0; i < 16; i++)
        begin
            r        = next_random();
            addrs[i] = {1'b0, r[22:8]};
            shadow[addrs[i][14:0]] = r[31:24];   // later writes to the same address win.
            apb_write(addrs[i], r[31:24], err);
            err_seen = err_seen | err;
        end
        for (int i = 0; i < 16; i++)
        begin
            apb_read(addrs[i], rd, err);
            err_seen = err_seen | err;
            if (rd != shadow[addrs[i][14:0]])
            begin
                $display("[ERROR] sram_write_read: at 0x%h expected 0x%h actual 0x%h",
                         addrs[i], shadow[addrs[i][14:0]], rd);
                errors++;
            end
        end
        if (err_seen)
        begin
            $display("sram_write_read: an SRAM transfer ended with pslverr high");
            errors++;
        end
        if (drive_faults != faults_before)
        begin
            $display("sram_write_read: data bus direction was wrong for %0d cycles",
                     drive_faults - faults_before);
            errors++;
        end
        report_result("sram_write_read", err_before);
    endtask

    task automatic nand_cmd_addr();
        byte_t bytes [3];
        logic  is_cmd [3];
        logic  err;
        int    log_start;
        int    ov_before;
        int    err_before;
        err_before = errors;
        bytes      = '{8'h90, 8'h12, 8'h34};
        is_cmd     = '{1'b1, 1'b0, 1'b0};
        log_start  = i_nand_model.log_data.size();
        ov_before  = overlap_cycles;
        for (int i = 0; i < 3; i++)
        begin
            apb_write(is_cmd[i] ? 16'h8000 : 16'h8001, bytes[i], err);
            if (err)
            begin
                $display("nand_cmd_addr: write of 0x%h ended with pslverr high", bytes[i]);
                errors++;
            end
        end
        if (i_nand_model.log_data.size() != log_start + 3)
        begin
            $display("[ERROR] nand_cmd_addr: log entries expected 3 actual %0d",
                     i_nand_model.log_data.size() - log_start);
            errors++;
        end
        else
        begin
            for (int i = 0; i < 3; i++)
            begin
                if ({i_nand_model.log_is_cmd[log_start + i],
                     i_nand_model.log_data[log_start + i]} != {is_cmd[i], bytes[i]})
                begin
                    $display("[ERROR] nand_cmd_addr: entry %0d expected cmd=%b 0x%h actual cmd=%b 0x%h",
                             i, is_cmd[i], bytes[i], i_nand_model.log_is_cmd[log_start + i],
                             i_nand_model.log_data[log_start + i]);
                    errors++;
                end
            end
        end
        if (overlap_cycles != ov_before)
        begin
            $display("nand_cmd_addr: cle and ale were high together for %0d cycles",
                     overlap_cycles - ov_before);
            errors++;
        end
        report_result("nand_cmd_addr", err_before);
    endtask

    task automatic nand_data_path();
        byte_t       wbytes [8];
        logic [31:0] r;
        apb_data_t   rd;
        logic        err;
        logic        err_seen;
        int          faults_before;
        int          err_before;
        err_before    = errors;
        faults_before = drive_faults;
        apb_write(16'h8000, 8'h80, err);   // program setup.
        err_seen = err;
        for (int i = 0; i < 8; i++)
        begin
            r         = next_random();
            wbytes[i] = r[31:24];
            apb_write(16'h8002, wbytes[i], err);
            err_seen = err_seen | err;
        end
        apb_write(16'h8000, 8'h00, err);   // read command, pointers back to 0.
        err_seen = err_seen | err;
        for (int i = 0; i < 8; i++)
        begin
            apb_read(16'h8002, rd, err);
            err_seen = err_seen | err;
            if (rd != wbytes[i])
            begin
                $display("[ERROR] nand_data_path: byte %0d expected 0x%h actual 0x%h",
                         i, wbytes[i], rd);
                errors++;
            end
        end
        if (err_seen)
        begin
            $display("nand_data_path: a NAND transfer ended with pslverr high");
            errors++;
        end
        if (drive_faults != faults_before)
        begin
            $display("nand_data_path: data bus direction was wrong for %0d cycles",
                     drive_faults - faults_before);
            errors++;
        end
        report_result("nand_data_path", err_before);
    endtask

    task automatic status_and_errors();
        apb_addr_t bad [2];
        apb_data_t rd;
        logic      err;
        int        strobes_before;
        int        err_before;
        err_before = errors;
        for (int level = 0; level <= 1; level++)
        begin
            @(posedge clk);
            nand_rb <= level[0];
            repeat (4) @(posedge clk);   // through the ready/busy synchronizer.
            apb_read(16'h8003, rd, err);
            if (rd != {7'd0, level[0]})
            begin
                $display("[ERROR] status_and_errors: status expected 0x%h actual 0x%h",
                         {7'd0, level[0]}, rd);
                errors++;
            end
            if (err)
            begin
                $display("status_and_errors: status read ended with pslverr high");
                errors++;
            end
        end
        bad            = '{16'h8004, 16'hc000};
        strobes_before = strobe_cycles;
        for (int i = 0; i < 2; i++)
        begin
            apb_read(bad[i], rd, err);
            if (!err || (rd != 8'h00))
            begin
                $display("[ERROR] status_and_errors: read 0x%h expected err=1 0x00 actual err=%b 0x%h",
                         bad[i], err, rd);
                errors++;
            end
            apb_write(bad[i], 8'ha5, err);
            if (!err)
            begin
                $display("[ERROR] status_and_errors: write 0x%h pslverr expected 1 actual 0",
                         bad[i]);
                errors++;
            end
        end
        if (strobe_cycles != strobes_before)
        begin
            $display("[ERROR] status_and_errors: strobe cycles expected 0 actual %0d",
                     strobe_cycles - strobes_before);
            errors++;
        end
        report_result("status_and_errors", err_before);
    endtask

    initial
    begin
        reset   = 1'b1;
        apb_req = '0;
        nand_rb = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_reset_state();
        sram_write_read();
        nand_cmd_addr();
        nand_data_path();
        status_and_errors();
        $display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verif/mem_models.sv
module sram_model
(
    input  logic                    clk,
    input  ext_mem_pkg::sram_pins_t pins,
    output ext_mem_pkg::byte_t      dout
);
    timeunit 1ns;
    timeprecision 100ps;

    import ext_mem_pkg::*;

    byte_t mem [0:32767];

    initial
    begin
        for (int i = 0; i < 32768; i++)
            mem[i] = i[7:0] ^ {1'b0, i[14:8]};
    end

    always @(posedge clk)
    begin
        if (!pins.ce_n && !pins.we_n)
            mem[pins.addr[14:0]] <= pins.dout;
    end

    assign dout = (!pins.ce_n && !pins.oe_n) ? mem[pins.addr[14:0]] : 8'h00;

endmodule

module nand_model
(
    input  ext_mem_pkg::nand_pins_t pins,
    output ext_mem_pkg::byte_t      dout
);
    timeunit 1ns;
    timeprecision 100ps;

    import ext_mem_pkg::*;

    logic       nwe;
    logic       nre;
    byte_t      page_buf [16];
    logic [3:0] wr_ptr      = '0;
    logic [3:0] reads_total = '0;
    logic [3:0] read_base   = '0;   // read pointer is reads_total - read_base.
    byte_t      log_data [$];
    logic       log_is_cmd [$];

    assign nwe  = pins.nwe;
    assign nre  = pins.nre;
    assign dout = page_buf[reads_total - read_base];

    always @(posedge nwe)
    begin
        if (!pins.nce)
        begin
            if (pins.cle || pins.ale)
            begin
                log_data.push_back(pins.dout);
                log_is_cmd.push_back(pins.cle);
            end
            if (pins.cle)
            begin
                wr_ptr    = '0;   // a command restarts both pointers.
                read_base = reads_total;
            end
            else if (!pins.ale)
            begin
                page_buf[wr_ptr] = pins.dout;
                wr_ptr           = wr_ptr + 4'd1;
            end
        end
    end

    always @(posedge nre)
    begin
        if (!pins.nce)
            reads_total = reads_total + 4'd1;
    end

endmodule

// File: hdl/ext_mem_top.sv
module ext_mem_top
#(
    parameter int SRAM_WAIT  = 2,
    parameter int NAND_PULSE = 3,
    parameter int NAND_HOLD  = 2
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  apb_pkg::apb_req_t       apb_req,
    output apb_pkg::apb_rsp_t       apb_rsp,
    output ext_mem_pkg::sram_pins_t sram_pins,
    input  ext_mem_pkg::byte_t      sram_din,
    output ext_mem_pkg::nand_pins_t nand_pins,
    input  ext_mem_pkg::byte_t      nand_din,
    input  logic                    nand_rb
);

    import ext_mem_pkg::*;

    target_req_t sram_req;
    target_req_t nand_req;
    target_rsp_t sram_rsp;
    target_rsp_t nand_rsp;

    apb_mem_decode i_apb_mem_decode
    (
        .clk      (clk),
        .reset    (reset),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .sram_req (sram_req),
        .nand_req (nand_req),
        .sram_rsp (sram_rsp),
        .nand_rsp (nand_rsp)
    );

    sram_port #(.SRAM_WAIT(SRAM_WAIT)) i_sram_port
    (
        .clk      (clk),
        .reset    (reset),
        .req      (sram_req),
        .rsp      (sram_rsp),
        .pins     (sram_pins),
        .sram_din (sram_din)
    );

    nand_port #(.NAND_PULSE(NAND_PULSE), .NAND_HOLD(NAND_HOLD)) i_nand_port
    (
        .clk      (clk),
        .reset    (reset),
        .req      (nand_req),
        .rsp      (nand_rsp),
        .pins     (nand_pins),
        .nand_din (nand_din),
        .nand_rb  (nand_rb)
    );

endmodule

// File: hdl/nand_port.sv
module nand_port
#(
    parameter int NAND_PULSE = 3,
    parameter int NAND_HOLD  = 2
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  ext_mem_pkg::target_req_t req,
    output ext_mem_pkg::target_rsp_t rsp,
    output ext_mem_pkg::nand_pins_t  pins,
    input  ext_mem_pkg::byte_t       nand_din,
    input  logic                     nand_rb
);

    import ext_mem_pkg::*;

    localparam int CNT_MAX = (NAND_PULSE > NAND_HOLD) ? NAND_PULSE : NAND_HOLD;
    localparam int CNT_W   = (CNT_MAX > 1) ? $clog2(CNT_MAX) : 1;

    typedef enum logic [1:0] {ST_IDLE, ST_PULSE, ST_HOLD, ST_DONE} state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    nand_reg_e        kind;
    nand_reg_e        kind_q;
    logic             write_q;
    byte_t            wdata_q;
    byte_t            rdata_q;
    logic [1:0]       rb_sync;
    logic             status_hit;
    logic             active;

    assign kind       = nand_reg_e'(req.addr[1:0]);
    assign status_hit = (state == ST_IDLE) && req.start && (kind == NAND_STATUS);

    // ready/busy comes from the device unclocked.
    always_ff @(posedge clk)
    begin
        if (reset)
            rb_sync <= '0;
        else
            rb_sync <= {rb_sync[0], nand_rb};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pulse then hold, one counter for both
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (req.start && (kind != NAND_STATUS))
                    begin
                        state <= ST_PULSE;
                        cnt   <= CNT_W'(NAND_PULSE - 1);
                    end
                ST_PULSE:
                    if (cnt == '0)
                    begin
                        state <= ST_HOLD;
                        cnt   <= CNT_W'(NAND_HOLD - 1);
                    end
                    else
                        cnt <= cnt - 1'b1;
                ST_HOLD:
                    if (cnt == '0)
                        state <= ST_DONE;
                    else
                        cnt <= cnt - 1'b1;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && req.start)
        begin
            kind_q  <= kind;
            write_q <= req.write;
            wdata_q <= req.wdata;
        end
        if ((state == ST_PULSE) && (cnt == '0) && !write_q && (kind_q == NAND_DATA))
            rdata_q <= nand_din;   // last low cycle of nre.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pins
    assign active = (state == ST_PULSE) || (state == ST_HOLD);

    // nwe rises while cle/ale are still up.
    assign pins = '{dout: wdata_q,
                    oe:   active && write_q,
                    nce:  !active,
                    cle:  active && (kind_q == NAND_CMD),
                    ale:  active && (kind_q == NAND_ADDR),
                    nwe:  !((state == ST_PULSE) && write_q),
                    nre:  !((state == ST_PULSE) && !write_q)};

    assign rsp = '{done:  status_hit || (state == ST_DONE),
                   rdata: status_hit ? byte_t'(rb_sync[1]) : rdata_q};

endmodule

// File: hdl/sram_port.sv
module sram_port
#(
    parameter int SRAM_WAIT = 2
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  ext_mem_pkg::target_req_t req,
    output ext_mem_pkg::target_rsp_t rsp,
    output ext_mem_pkg::sram_pins_t  pins,
    input  ext_mem_pkg::byte_t       sram_din
);

    import ext_mem_pkg::*;

    localparam int CNT_W = (SRAM_WAIT > 1) ? $clog2(SRAM_WAIT) : 1;

    typedef enum logic [1:0] {ST_IDLE, ST_STROBE, ST_FINISH} state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    logic             write_q;
    sram_addr_t       addr_q;
    byte_t            wdata_q;
    byte_t            rdata_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (req.start)
                    begin
                        state <= ST_STROBE;
                        cnt   <= CNT_W'(SRAM_WAIT - 1);
                    end
                ST_STROBE:
                    if (cnt == '0)
                        state <= ST_FINISH;
                    else
                        cnt <= cnt - 1'b1;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // address and data held for the whole cycle.
    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && req.start)
        begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            write_q <= req.write;
        end
        if ((state == ST_STROBE) && (cnt == '0) && !write_q)
            rdata_q <= sram_din;   // last strobe cycle.
    end

    assign pins = '{addr: addr_q,
                    dout: wdata_q,
                    oe:   write_q && (state != ST_IDLE),
                    ce_n: state != ST_STROBE,
                    we_n: !((state == ST_STROBE) && write_q),
                    oe_n: !((state == ST_STROBE) && !write_q)};

    assign rsp = '{done: state == ST_FINISH, rdata: rdata_q};

endmodule

// File: hdl/apb_mem_decode.sv
module apb_mem_decode
(
    input  logic                     clk,
    input  logic                     reset,
    input  apb_pkg::apb_req_t        apb_req,
    output apb_pkg::apb_rsp_t        apb_rsp,
    output ext_mem_pkg::target_req_t sram_req,
    output ext_mem_pkg::target_req_t nand_req,
    input  ext_mem_pkg::target_rsp_t sram_rsp,
    input  ext_mem_pkg::target_rsp_t nand_rsp
);

    import ext_mem_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_RESPOND} state_e;
    typedef enum logic [1:0] {TGT_SRAM, TGT_NAND, TGT_ERR} target_e;

    state_e  state;
    target_e tgt;
    target_e tgt_q;
    target_e tgt_sel;
    logic    setup;
    logic    done;
    byte_t   rdata;
    logic    pready_q;
    logic    pslverr_q;
    byte_t   prdata_q;

    // address map.
    always_comb
    begin
        if (!apb_req.paddr[15])
            tgt = TGT_SRAM;
        else if (apb_req.paddr[14:2] == '0)
            tgt = TGT_NAND;
        else
            tgt = TGT_ERR;
    end

    assign setup = (state == ST_IDLE) && apb_req.psel && !apb_req.penable;

    // start is seen by the port on the edge that ends setup.
    assign sram_req = '{start: setup && (tgt == TGT_SRAM),
                        write: apb_req.pwrite,
                        addr:  {1'b0, apb_req.paddr[14:0]},
                        wdata: apb_req.pwdata};
    assign nand_req = '{start: setup && (tgt == TGT_NAND),
                        write: apb_req.pwrite,
                        addr:  sram_addr_t'(apb_req.paddr[1:0]),
                        wdata: apb_req.pwdata};

    // status answers in the setup cycle itself.
    assign tgt_sel = (state == ST_IDLE) ? tgt : tgt_q;
    assign done    = (tgt_sel == TGT_SRAM) ? sram_rsp.done :
                     (tgt_sel == TGT_NAND) ? nand_rsp.done : 1'b0;
    assign rdata   = (tgt_sel == TGT_SRAM) ? sram_rsp.rdata : nand_rsp.rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= ST_IDLE;
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (setup)
                    begin
                        if (tgt == TGT_ERR)
                        begin
                            pready_q  <= 1'b1;
                            pslverr_q <= 1'b1;
                            state     <= ST_RESPOND;
                        end
                        else if (done)
                        begin
                            pready_q <= 1'b1;
                            state    <= ST_RESPOND;
                        end
                        else
                            state <= ST_BUSY;
                    end
                ST_BUSY:
                    if (done)
                    begin
                        pready_q <= 1'b1;
                        state    <= ST_RESPOND;
                    end
                default:
                begin
                    pready_q  <= 1'b0;   // one cycle only.
                    pslverr_q <= 1'b0;
                    state     <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (setup)
            tgt_q <= tgt;
        if (done)
            prdata_q <= rdata;
        else if (setup && (tgt == TGT_ERR))
            prdata_q <= '0;
    end

    assign apb_rsp = '{prdata: prdata_q, pready: pready_q, pslverr: pslverr_q};

endmodule

// File: hdl/ext_mem_pkg.sv
package ext_mem_pkg;

    localparam int BYTE_W      = 8;
    localparam int SRAM_ADDR_W = 16;

    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;   // bit 15 stays low, 32 KiB window.

    // NAND register offsets above 0x8000.
    typedef enum logic [1:0] {
        NAND_CMD    = 2'd0,
        NAND_ADDR   = 2'd1,
        NAND_DATA   = 2'd2,
        NAND_STATUS = 2'd3
    } nand_reg_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoder <-> port handshake
    typedef struct packed {
        logic       start;   // one cycle.
        logic       write;
        sram_addr_t addr;
        byte_t      wdata;
    } target_req_t;

    typedef struct packed {
        logic  done;         // one cycle, rdata valid with it.
        byte_t rdata;
    } target_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pin bundles, data bus split into dout and oe
    typedef struct packed {
        sram_addr_t addr;
        byte_t      dout;
        logic       oe;
        logic       ce_n;
        logic       we_n;
        logic       oe_n;
    } sram_pins_t;

    typedef struct packed {
        byte_t dout;
        logic  oe;
        logic  nce;
        logic  cle;
        logic  ale;
        logic  nwe;
        logic  nre;
    } nand_pins_t;

endpackage

// File: hdl/apb_pkg.sv
package apb_pkg;

    localparam int APB_ADDR_W = 16;
    localparam int APB_DATA_W = 8;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // master to slave, held until pready.
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // slave to master, valid with pready only.
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage
